/* source/hazard_pkg.sv */
package hazard_pkg;

   typedef logic [31:0] instr_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [5:0]  opcode_t;
   typedef logic [5:0]  funct_t;

   localparam reg_idx_t link_reg_idx = 5'd31;

   // instruction field positions
   localparam int op_hi = 31;
   localparam int op_lo = 26;
   localparam int rs_hi = 25;
   localparam int rs_lo = 21;
   localparam int rt_hi = 20;
   localparam int rt_lo = 16;
   localparam int rd_hi = 15;
   localparam int rd_lo = 11;
   localparam int sa_hi = 10;
   localparam int sa_lo = 6;
   localparam int fn_hi = 5;
   localparam int fn_lo = 0;

   localparam opcode_t op_special = 6'b000000;
   localparam opcode_t op_regimm  = 6'b000001;
   localparam opcode_t op_j       = 6'b000010;
   localparam opcode_t op_jal     = 6'b000011;
   localparam opcode_t op_beq     = 6'b000100;
   localparam opcode_t op_bne     = 6'b000101;
   localparam opcode_t op_blez    = 6'b000110;
   localparam opcode_t op_bgtz    = 6'b000111;
   localparam opcode_t op_addi    = 6'b001000;
   localparam opcode_t op_addiu   = 6'b001001;
   localparam opcode_t op_slti    = 6'b001010;
   localparam opcode_t op_sltiu   = 6'b001011;
   localparam opcode_t op_andi    = 6'b001100;
   localparam opcode_t op_ori     = 6'b001101;
   localparam opcode_t op_xori    = 6'b001110;
   localparam opcode_t op_lui     = 6'b001111;
   localparam opcode_t op_lb      = 6'b100000;
   localparam opcode_t op_lh      = 6'b100001;
   localparam opcode_t op_lw      = 6'b100011;
   localparam opcode_t op_lbu     = 6'b100100;
   localparam opcode_t op_lhu     = 6'b100101;
   localparam opcode_t op_sb      = 6'b101000;
   localparam opcode_t op_sh      = 6'b101001;
   localparam opcode_t op_sw      = 6'b101011;
   localparam opcode_t op_lwg     = 6'b111100; // custom gather load
   localparam opcode_t op_swg     = 6'b111101;

   localparam funct_t fn_sll   = 6'b000000;
   localparam funct_t fn_srl   = 6'b000010;
   localparam funct_t fn_sra   = 6'b000011;
   localparam funct_t fn_sllv  = 6'b000100;
   localparam funct_t fn_srlv  = 6'b000110;
   localparam funct_t fn_srav  = 6'b000111;
   localparam funct_t fn_jr    = 6'b001000;
   localparam funct_t fn_jalr  = 6'b001001;
   localparam funct_t fn_mfhi  = 6'b010000;
   localparam funct_t fn_mthi  = 6'b010001;
   localparam funct_t fn_mflo  = 6'b010010;
   localparam funct_t fn_mtlo  = 6'b010011;
   localparam funct_t fn_mult  = 6'b011000;
   localparam funct_t fn_multu = 6'b011001;
   localparam funct_t fn_div   = 6'b011010;
   localparam funct_t fn_divu  = 6'b011011;
   localparam funct_t fn_add   = 6'b100000;
   localparam funct_t fn_addu  = 6'b100001;
   localparam funct_t fn_sub   = 6'b100010;
   localparam funct_t fn_subu  = 6'b100011;
   localparam funct_t fn_and   = 6'b100100;
   localparam funct_t fn_or    = 6'b100101;
   localparam funct_t fn_xor   = 6'b100110;
   localparam funct_t fn_nor   = 6'b100111;
   localparam funct_t fn_slt   = 6'b101010;
   localparam funct_t fn_sltu  = 6'b101011;

   typedef struct packed {
      logic cal_r;
      logic cal_i;
      logic load;
      logic store;
      logic branch;  // beq/bne
      logic jr;      // jr, blez/bgtz, bgez family
      logic jalr;
      logic jal;     // jal, bgezal/bltzal
      logic mf;
      logic mdft;    // any hi/lo user
      logic jump;
      logic spare;
   } instr_class_t;

   typedef struct packed {
      instr_class_t cls;
      reg_idx_t     dst;
      reg_idx_t     rs;
      reg_idx_t     rt;
   } stage_info_t;

   typedef enum logic [2:0] {
      fwd_d_none      = 3'd0,
      fwd_d_m_alu     = 3'd1,
      fwd_d_m_link    = 3'd2,
      fwd_d_m_hilo    = 3'd3,
      fwd_d_mmid_alu  = 3'd4,
      fwd_d_mmid_link = 3'd5,
      fwd_d_mmid_hilo = 3'd6
   } fwd_d_sel_e;

   typedef enum logic [3:0] {
      fwd_e_none      = 4'd0,
      fwd_e_m_alu     = 4'd1,
      fwd_e_w_alu     = 4'd2,
      fwd_e_m_link    = 4'd3,
      fwd_e_w_link    = 4'd4,
      fwd_e_m_hilo    = 4'd5,
      fwd_e_w_hilo    = 4'd6,
      fwd_e_mmid_alu  = 4'd7,
      fwd_e_mmid_link = 4'd8,
      fwd_e_mmid_hilo = 4'd9
   } fwd_e_sel_e;

   typedef struct packed {
      logic en;
      logic clr;
   } stage_ctrl_t;

   // $0 never matches
   function automatic logic dst_match(reg_idx_t src, reg_idx_t dst);
      return (src != '0) && (src == dst);
   endfunction

endpackage

/* source/instr_classifier.sv */
module instr_classifier
   import hazard_pkg::*;
(
   input  instr_t      instr,
   output stage_info_t info
);

   opcode_t      op;
   funct_t       fn;
   reg_idx_t     rs;
   reg_idx_t     rt;
   reg_idx_t     rd;
   logic [4:0]   sa;
   logic         special;
   logic         alu_r;
   logic         shift_imm;
   logic         muldiv;
   logic         mt_hilo;
   logic         jr_reg;
   logic         blez_bgtz;
   logic         regimm_b;
   logic         regimm_link;
   instr_class_t cls;

   assign op = instr[op_hi:op_lo];
   assign rs = instr[rs_hi:rs_lo];
   assign rt = instr[rt_hi:rt_lo];
   assign rd = instr[rd_hi:rd_lo];
   assign sa = instr[sa_hi:sa_lo];
   assign fn = instr[fn_hi:fn_lo];

   assign special = (op == op_special);

   assign alu_r = special && (sa == '0)
                  && (fn inside {fn_add, fn_addu, fn_sub, fn_subu, fn_and, fn_or, fn_xor,
                                 fn_nor, fn_slt, fn_sltu, fn_sllv, fn_srlv, fn_srav});
   assign shift_imm = special && (rs == '0) && (fn inside {fn_sll, fn_srl, fn_sra});
   assign muldiv = special && (rd == '0) && (sa == '0)
                   && (fn inside {fn_mult, fn_multu, fn_div, fn_divu});
   assign mt_hilo = special && (rt == '0) && (rd == '0) && (sa == '0)
                    && (fn inside {fn_mthi, fn_mtlo});

   assign jr_reg = special && (rt == '0) && (rd == '0) && (sa == '0) && (fn == fn_jr);
   assign blez_bgtz = (op inside {op_blez, op_bgtz}) && (rt == '0);
   assign regimm_b = (op == op_regimm) && (rt[3:1] == 3'b000); // bgez/bltz and linking forms
   assign regimm_link = (op == op_regimm) && (rt[4:1] == 4'b1000);

   assign cls.cal_r = alu_r | shift_imm | muldiv | mt_hilo;
   assign cls.cal_i = (op inside {op_addi, op_addiu, op_andi, op_ori, op_xori, op_slti,
                                  op_sltiu})
                      || ((op == op_lui) && (rs == '0));
   assign cls.load = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwg};
   assign cls.store = op inside {op_sb, op_sh, op_sw, op_swg};
   assign cls.branch = op inside {op_beq, op_bne};
   assign cls.jr = jr_reg | blez_bgtz | regimm_b;
   assign cls.jalr = special && (rt == '0) && (sa == '0) && (fn == fn_jalr);
   assign cls.jal = (op == op_jal) | regimm_link;
   assign cls.mf = special && (rs == '0) && (rt == '0) && (sa == '0)
                   && (fn inside {fn_mfhi, fn_mflo});
   assign cls.mdft = muldiv | mt_hilo | cls.mf;
   assign cls.jump = (op inside {op_j, op_jal}) | cls.branch | cls.jr | cls.jalr;
   assign cls.spare = 1'b0;

   always_comb begin
      info.cls = cls;
      info.rs  = rs;
      info.rt  = rt;
      if (cls.cal_r || cls.jalr || cls.mf) begin
         info.dst = rd;
      end else if (cls.cal_i || cls.load) begin
         info.dst = rt;
      end else if (cls.jal) begin
         info.dst = link_reg_idx; // return address into $ra
      end else begin
         info.dst = '0;
      end
   end

endmodule

/* source/stall_detector.sv */
module stall_detector
   import hazard_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  stage_info_t info_d,
   input  stage_info_t info_e,
   input  stage_info_t info_m,
   input  stage_info_t info_mmid,
   input  logic        md_busy,
   output logic        stall
);

   logic e_result;
   logic rs_e;
   logic rt_e;
   logic rs_ld_e;
   logic rt_ld_e;
   logic rs_ld_m;
   logic rt_ld_m;
   logic rs_ld_mmid;
   logic rt_ld_mmid;
   logic stall_branch;
   logic stall_jr;
   logic stall_load;
   logic stall_md;

   // E result not ready for a compare in D
   assign e_result = info_e.cls.cal_r | info_e.cls.cal_i | info_e.cls.load | info_e.cls.mf;

   assign rs_e = e_result && dst_match(info_d.rs, info_e.dst);
   assign rt_e = e_result && dst_match(info_d.rt, info_e.dst);

   assign rs_ld_e = info_e.cls.load && dst_match(info_d.rs, info_e.dst);
   assign rt_ld_e = info_e.cls.load && dst_match(info_d.rt, info_e.dst);
   assign rs_ld_m = info_m.cls.load && dst_match(info_d.rs, info_m.dst);
   assign rt_ld_m = info_m.cls.load && dst_match(info_d.rt, info_m.dst);
   assign rs_ld_mmid = info_mmid.cls.load && dst_match(info_d.rs, info_mmid.dst);
   assign rt_ld_mmid = info_mmid.cls.load && dst_match(info_d.rt, info_mmid.dst);

   assign stall_branch = info_d.cls.branch
                         && (rs_e || rt_e || rs_ld_m || rt_ld_m || rs_ld_mmid || rt_ld_mmid);

   assign stall_jr = (info_d.cls.jr || info_d.cls.jalr) && (rs_e || rs_ld_m || rs_ld_mmid);

   // load-use, operand needed in E
   assign stall_load = ((info_d.cls.cal_r || info_d.cls.cal_i || info_d.cls.load
                         || info_d.cls.store) && (rs_ld_e || rs_ld_m))
                       || ((info_d.cls.cal_r || info_d.cls.store) && (rt_ld_e || rt_ld_m));

   assign stall_md = info_d.cls.mdft && md_busy;

   assign stall = stall_branch | stall_jr | stall_load | stall_md;

   // an instruction that reads only $0 must flow, the nop included
   a_nop_no_stall: assert property (@(posedge clk) disable iff (reset)
      (info_d.rs == '0 && info_d.rt == '0 && !info_d.cls.mdft) |-> !stall);

endmodule

/* source/forward_unit.sv */
module forward_unit
   import hazard_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  stage_info_t info_d,
   input  stage_info_t info_e,
   input  stage_info_t info_m,
   input  stage_info_t info_mmid,
   input  stage_info_t info_w,
   output fwd_d_sel_e  fwd_rs_d,
   output fwd_d_sel_e  fwd_rt_d,
   output fwd_e_sel_e  fwd_rs_e,
   output fwd_e_sel_e  fwd_rt_e
);

   logic d_rs_reader;
   logic d_rt_reader;
   logic e_rs_reader;
   logic e_rt_reader;

   // load data only exists from W on
   function automatic logic is_alu(instr_class_t c, logic w_stage);
      return c.cal_r | c.cal_i | (w_stage & c.load);
   endfunction

   function automatic logic is_link(instr_class_t c);
      return c.jal | c.jalr;
   endfunction

   function automatic fwd_d_sel_e sel_d(reg_idx_t src, stage_info_t m, stage_info_t mmid);
      logic hit_m;
      logic hit_mmid;
      hit_m    = dst_match(src, m.dst);
      hit_mmid = dst_match(src, mmid.dst);
      if (hit_m && is_alu(m.cls, 1'b0)) return fwd_d_m_alu;
      else if (hit_m && is_link(m.cls)) return fwd_d_m_link;
      else if (hit_m && m.cls.mf) return fwd_d_m_hilo;
      else if (hit_mmid && is_alu(mmid.cls, 1'b0)) return fwd_d_mmid_alu;
      else if (hit_mmid && is_link(mmid.cls)) return fwd_d_mmid_link;
      else if (hit_mmid && mmid.cls.mf) return fwd_d_mmid_hilo;
      else return fwd_d_none;
   endfunction

   function automatic fwd_e_sel_e sel_e(reg_idx_t src, stage_info_t m, stage_info_t mmid,
                                        stage_info_t w);
      logic hit_m;
      logic hit_mmid;
      logic hit_w;
      hit_m    = dst_match(src, m.dst);
      hit_mmid = dst_match(src, mmid.dst);
      hit_w    = dst_match(src, w.dst);
      if (hit_m && is_alu(m.cls, 1'b0)) return fwd_e_m_alu;
      else if (hit_m && is_link(m.cls)) return fwd_e_m_link;
      else if (hit_m && m.cls.mf) return fwd_e_m_hilo;
      else if (hit_mmid && is_alu(mmid.cls, 1'b0)) return fwd_e_mmid_alu;
      else if (hit_mmid && is_link(mmid.cls)) return fwd_e_mmid_link;
      else if (hit_mmid && mmid.cls.mf) return fwd_e_mmid_hilo;
      else if (hit_w && is_alu(w.cls, 1'b1)) return fwd_e_w_alu;
      else if (hit_w && is_link(w.cls)) return fwd_e_w_link;
      else if (hit_w && w.cls.mf) return fwd_e_w_hilo;
      else return fwd_e_none;
   endfunction

   // D reads operands only for branch targets and compares
   assign d_rs_reader = info_d.cls.branch | info_d.cls.jr | info_d.cls.jalr;
   assign d_rt_reader = info_d.cls.branch;
   assign e_rs_reader = info_e.cls.cal_r | info_e.cls.cal_i | info_e.cls.load
                        | info_e.cls.store;
   assign e_rt_reader = info_e.cls.cal_r | info_e.cls.store;

   assign fwd_rs_d = d_rs_reader ? sel_d(info_d.rs, info_m, info_mmid) : fwd_d_none;
   assign fwd_rt_d = d_rt_reader ? sel_d(info_d.rt, info_m, info_mmid) : fwd_d_none;

   assign fwd_rs_e = e_rs_reader ? sel_e(info_e.rs, info_m, info_mmid, info_w) : fwd_e_none;
   assign fwd_rt_e = e_rt_reader ? sel_e(info_e.rt, info_m, info_mmid, info_w) : fwd_e_none;

   // decode forwarding only ever feeds a control transfer
   a_fwd_d_src: assert property (@(posedge clk) disable iff (reset)
      ((fwd_rs_d != fwd_d_none) |-> (info_d.rs != '0 && info_d.cls.jump))
      and ((fwd_rt_d != fwd_d_none) |-> (info_d.rt != '0 && info_d.cls.jump)));

   a_fwd_e_src: assert property (@(posedge clk) disable iff (reset)
      ((fwd_rs_e != fwd_e_none) |-> (info_e.rs != '0))
      and ((fwd_rt_e != fwd_e_none) |-> (info_e.rt != '0)));

endmodule

/* source/pipeline_ctrl.sv */
module pipeline_ctrl
   import hazard_pkg::*;
(
   input  logic         clk,
   input  logic         reset,
   input  logic         stall,
   input  instr_class_t cls_m,
   input  instr_class_t cls_mmid,
   input  logic         mem_addr_ok,
   input  logic         mem_data_ok,
   input  fwd_e_sel_e   fwd_rs_e,
   input  fwd_e_sel_e   fwd_rt_e,
   output stage_ctrl_t  if_id_ctrl,
   output stage_ctrl_t  id_ex_ctrl,
   output logic         ex_mem_en,
   output stage_ctrl_t  mem_mmid_ctrl,
   output stage_ctrl_t  mmid_wb_ctrl,
   output logic         data_sram_wr
);

   logic mem_op_m;
   logic mem_op_mmid;
   logic mem_mmid_en;
   logic id_ex_en;
   logic if_id_en;
   logic w_fwd;

   function automatic logic from_w(fwd_e_sel_e sel);
      return sel inside {fwd_e_w_alu, fwd_e_w_link, fwd_e_w_hilo};
   endfunction

   assign mem_op_m    = cls_m.load | cls_m.store;
   assign mem_op_mmid = cls_mmid.load | cls_mmid.store;

   assign mem_mmid_en = mem_op_mmid ? mem_data_ok : 1'b1; // wait for read/write data
   assign ex_mem_en   = mem_mmid_en && (!mem_op_m || mem_addr_ok);
   assign id_ex_en    = ex_mem_en;
   assign if_id_en    = id_ex_en && !stall; // also holds the PC

   // E still needs the W value, keep it there
   assign w_fwd = from_w(fwd_rs_e) || from_w(fwd_rt_e);

   assign if_id_ctrl    = '{en: if_id_en, clr: 1'b0};
   assign id_ex_ctrl    = '{en: id_ex_en, clr: id_ex_en && !if_id_en};
   assign mem_mmid_ctrl = '{en: mem_mmid_en, clr: mem_mmid_en && !ex_mem_en};
   assign mmid_wb_ctrl  = '{en: mem_mmid_en || !w_fwd, clr: !mem_mmid_en && !w_fwd};

   assign data_sram_wr = cls_m.store;

   // a stage never advances into a held one
   a_enable_chain: assert property (@(posedge clk) disable iff (reset)
      (!if_id_ctrl.en || id_ex_ctrl.en) && (!id_ex_ctrl.en || ex_mem_en)
      && (!ex_mem_en || mem_mmid_ctrl.en) && (!mem_mmid_ctrl.en || mmid_wb_ctrl.en));

endmodule

/* source/hazard_unit.sv */
module hazard_unit
   import hazard_pkg::*;
(
   input  logic        clk,
   input  logic        reset,
   input  instr_t      instr_d,
   input  instr_t      instr_e,
   input  instr_t      instr_m,
   input  instr_t      instr_mmid,
   input  instr_t      instr_w,
   input  logic        md_busy,
   input  logic        mem_addr_ok,
   input  logic        mem_data_ok,
   output fwd_d_sel_e  fwd_rs_d,
   output fwd_d_sel_e  fwd_rt_d,
   output fwd_e_sel_e  fwd_rs_e,
   output fwd_e_sel_e  fwd_rt_e,
   output stage_ctrl_t if_id_ctrl,
   output stage_ctrl_t id_ex_ctrl,
   output logic        ex_mem_en,
   output stage_ctrl_t mem_mmid_ctrl,
   output stage_ctrl_t mmid_wb_ctrl,
   output logic        data_sram_wr
);

   stage_info_t info_d;
   stage_info_t info_e;
   stage_info_t info_m;
   stage_info_t info_mmid;
   stage_info_t info_w;
   logic        stall;

   instr_classifier u_cls_d    (.instr(instr_d),    .info(info_d));
   instr_classifier u_cls_e    (.instr(instr_e),    .info(info_e));
   instr_classifier u_cls_m    (.instr(instr_m),    .info(info_m));
   instr_classifier u_cls_mmid (.instr(instr_mmid), .info(info_mmid));
   instr_classifier u_cls_w    (.instr(instr_w),    .info(info_w));

   stall_detector u_stall (
      .clk       (clk),
      .reset     (reset),
      .info_d    (info_d),
      .info_e    (info_e),
      .info_m    (info_m),
      .info_mmid (info_mmid),
      .md_busy   (md_busy),
      .stall     (stall)
   );

   forward_unit u_fwd (
      .clk       (clk),
      .reset     (reset),
      .info_d    (info_d),
      .info_e    (info_e),
      .info_m    (info_m),
      .info_mmid (info_mmid),
      .info_w    (info_w),
      .fwd_rs_d  (fwd_rs_d),
      .fwd_rt_d  (fwd_rt_d),
      .fwd_rs_e  (fwd_rs_e),
      .fwd_rt_e  (fwd_rt_e)
   );

   pipeline_ctrl u_ctrl (
      .clk           (clk),
      .reset         (reset),
      .stall         (stall),
      .cls_m         (info_m.cls),
      .cls_mmid      (info_mmid.cls),
      .mem_addr_ok   (mem_addr_ok),
      .mem_data_ok   (mem_data_ok),
      .fwd_rs_e      (fwd_rs_e),
      .fwd_rt_e      (fwd_rt_e),
      .if_id_ctrl    (if_id_ctrl),
      .id_ex_ctrl    (id_ex_ctrl),
      .ex_mem_en     (ex_mem_en),
      .mem_mmid_ctrl (mem_mmid_ctrl),
      .mmid_wb_ctrl  (mmid_wb_ctrl),
      .data_sram_wr  (data_sram_wr)
   );

endmodule

/* verif/hazard_unit_tb.sv */
module hazard_unit_tb
   import hazard_pkg::*;
();

   localparam int timeout_cycles = 1000; // stimulus needs under 100 cycles

   logic        clk = 1'b0;
   logic        reset;
   instr_t      instr_d;
   instr_t      instr_e;
   instr_t      instr_m;
   instr_t      instr_mmid;
   instr_t      instr_w;
   logic        md_busy;
   logic        mem_addr_ok;
   logic        mem_data_ok;
   fwd_d_sel_e  fwd_rs_d;
   fwd_d_sel_e  fwd_rt_d;
   fwd_e_sel_e  fwd_rs_e;
   fwd_e_sel_e  fwd_rt_e;
   stage_ctrl_t if_id_ctrl;
   stage_ctrl_t id_ex_ctrl;
   logic        ex_mem_en;
   stage_ctrl_t mem_mmid_ctrl;
   stage_ctrl_t mmid_wb_ctrl;
   logic        data_sram_wr;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   int unsigned seed_init;
   int          prod_kind [3]; // 0 addu, 1 addiu, 2 lw, 3 jal, 4 mfhi
   reg_idx_t    prod_dst [3];  // index 0 is M, 1 is MMID, 2 is W

   hazard_unit dut (
      .clk           (clk),
      .reset         (reset),
      .instr_d       (instr_d),
      .instr_e       (instr_e),
      .instr_m       (instr_m),
      .instr_mmid    (instr_mmid),
      .instr_w       (instr_w),
      .md_busy       (md_busy),
      .mem_addr_ok   (mem_addr_ok),
      .mem_data_ok   (mem_data_ok),
      .fwd_rs_d      (fwd_rs_d),
      .fwd_rt_d      (fwd_rt_d),
      .fwd_rs_e      (fwd_rs_e),
      .fwd_rt_e      (fwd_rt_e),
      .if_id_ctrl    (if_id_ctrl),
      .id_ex_ctrl    (id_ex_ctrl),
      .ex_mem_en     (ex_mem_en),
      .mem_mmid_ctrl (mem_mmid_ctrl),
      .mmid_wb_ctrl  (mmid_wb_ctrl),
      .data_sram_wr  (data_sram_wr)
   );

   always #5 clk = ~clk;

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout: run did not finish within %0d cycles", timeout_cycles);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   function automatic instr_t addu_word(reg_idx_t rd, reg_idx_t rs, reg_idx_t rt);
      return {6'b000000, rs, rt, rd, 5'b00000, 6'b100001};
   endfunction

   function automatic instr_t addiu_word(reg_idx_t rt, reg_idx_t rs);
      return {6'b001001, rs, rt, 16'h0004};
   endfunction

   function automatic instr_t lw_word(reg_idx_t rt, reg_idx_t base);
      return {6'b100011, base, rt, 16'h0010};
   endfunction

   function automatic instr_t sw_word(reg_idx_t rt, reg_idx_t base);
      return {6'b101011, base, rt, 16'h0010};
   endfunction

   function automatic instr_t beq_word(reg_idx_t rs, reg_idx_t rt);
      return {6'b000100, rs, rt, 16'h0003};
   endfunction

   function automatic instr_t jr_word(reg_idx_t rs);
      return {6'b000000, rs, 15'b0, 6'b001000};
   endfunction

   function automatic instr_t jal_word();
      return {6'b000011, 26'h0000040};
   endfunction

   function automatic instr_t mfhi_word(reg_idx_t rd);
      return {16'h0000, rd, 5'b00000, 6'b010000};
   endfunction

   function automatic instr_t mult_word(reg_idx_t rs, reg_idx_t rt);
      return {6'b000000, rs, rt, 10'b0, 6'b011000};
   endfunction

   // small indices collide often and 8 maps to $31 for jal
   function automatic reg_idx_t random_reg();
      int pick;
      pick = $urandom % 9;
      return (pick == 8) ? 5'd31 : reg_idx_t'(pick);
   endfunction

   function automatic instr_t producer_word(int kind, reg_idx_t r);
      case (kind)
         0: return addu_word(r, 5'd1, 5'd2);
         1: return addiu_word(r, 5'd3);
         2: return lw_word(r, 5'd4);
         3: return jal_word();
         default: return mfhi_word(r);
      endcase
   endfunction

   // walk from W towards M so the nearest usable producer wins
   function automatic fwd_e_sel_e expected_e_sel(reg_idx_t src);
      fwd_e_sel_e sel;
      sel = fwd_e_none;
      for (int s = 2; s >= 0; s--) begin
         if (src != 5'd0 && src == prod_dst[s]) begin
            if (prod_kind[s] <= 1 || (prod_kind[s] == 2 && s == 2)) begin
               sel = (s == 0) ? fwd_e_m_alu : (s == 1) ? fwd_e_mmid_alu : fwd_e_w_alu;
            end else if (prod_kind[s] == 3) begin
               sel = (s == 0) ? fwd_e_m_link : (s == 1) ? fwd_e_mmid_link : fwd_e_w_link;
            end else if (prod_kind[s] == 4) begin
               sel = (s == 0) ? fwd_e_m_hilo : (s == 1) ? fwd_e_mmid_hilo : fwd_e_w_hilo;
            end
         end
      end
      return sel;
   endfunction

   task automatic check_value(input string name, input int got, input int exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("CHECK FAILED at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic apply_inputs(input instr_t d, input instr_t e, input instr_t m,
                               input instr_t mmid, input instr_t w, input logic busy,
                               input logic addr_ok, input logic data_ok);
      @(posedge clk);
      instr_d     <= d;
      instr_e     <= e;
      instr_m     <= m;
      instr_mmid  <= mmid;
      instr_w     <= w;
      md_busy     <= busy;
      mem_addr_ok <= addr_ok;
      mem_data_ok <= data_ok;
      @(negedge clk); // outputs settled
   endtask

   task automatic e_forwarding_random();
      instr_t   prod [3];
      instr_t   e_word;
      reg_idx_t r;
      reg_idx_t src_rs;
      reg_idx_t src_rt;
      for (int n = 0; n < 50; n++) begin
         for (int s = 0; s < 3; s++) begin
            prod_kind[s] = $urandom % 5;
            r = random_reg();
            prod[s] = producer_word(prod_kind[s], r);
            prod_dst[s] = (prod_kind[s] == 3) ? 5'd31 : r;
         end
         src_rs = random_reg();
         src_rt = random_reg();
         if ($urandom % 2 == 1) begin
            e_word = addu_word(random_reg(), src_rs, src_rt);
         end else begin
            e_word = sw_word(src_rt, src_rs);
         end
         apply_inputs('0, e_word, prod[0], prod[1], prod[2], 1'b0, 1'b1, 1'b1);
         check_value("fwd_rs_e", int'(fwd_rs_e), int'(expected_e_sel(src_rs)));
         check_value("fwd_rt_e", int'(fwd_rt_e), int'(expected_e_sel(src_rt)));
      end
   endtask

   task automatic d_forwarding();
      apply_inputs(jr_word(5'd31), '0, jal_word(), '0, '0, 1'b0, 1'b1, 1'b1);
      check_value("fwd_rs_d", int'(fwd_rs_d), int'(fwd_d_m_link));
      apply_inputs(beq_word(5'd4, 5'd9), '0, '0, addu_word(5'd9, 5'd1, 5'd2), '0,
                   1'b0, 1'b1, 1'b1);
      check_value("fwd_rs_d", int'(fwd_rs_d), int'(fwd_d_none));
      check_value("fwd_rt_d", int'(fwd_rt_d), int'(fwd_d_mmid_alu));
      apply_inputs(beq_word(5'd12, 5'd3), '0, '0, mfhi_word(5'd12), '0, 1'b0, 1'b1, 1'b1);
      check_value("fwd_rs_d", int'(fwd_rs_d), int'(fwd_d_mmid_hilo));
      check_value("fwd_rt_d", int'(fwd_rt_d), int'(fwd_d_none));
      apply_inputs(beq_word(5'd12, 5'd3), '0, addu_word(5'd12, 5'd1, 5'd2),
                   mfhi_word(5'd12), '0, 1'b0, 1'b1, 1'b1);
      check_value("fwd_rs_d", int'(fwd_rs_d), int'(fwd_d_m_alu)); // M before MMID
      apply_inputs(beq_word(5'd12, 5'd3), '0, '0, '0, mfhi_word(5'd12), 1'b0, 1'b1, 1'b1);
      check_value("fwd_rs_d", int'(fwd_rs_d), int'(fwd_d_none)); // W is not a D source
      check_value("fwd_rt_d", int'(fwd_rt_d), int'(fwd_d_none));
   endtask

   task automatic load_and_branch_stall();
      apply_inputs(addu_word(5'd3, 5'd7, 5'd4), lw_word(5'd7, 5'd2), '0, '0, '0,
                   1'b0, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 0);
      check_value("if_id_ctrl.clr", int'(if_id_ctrl.clr), 0);
      check_value("id_ex_ctrl.en", int'(id_ex_ctrl.en), 1);
      check_value("id_ex_ctrl.clr", int'(id_ex_ctrl.clr), 1);
      apply_inputs(addu_word(5'd3, 5'd8, 5'd4), lw_word(5'd7, 5'd2), '0, '0, '0,
                   1'b0, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 1);
      check_value("id_ex_ctrl.clr", int'(id_ex_ctrl.clr), 0);
      apply_inputs(addu_word(5'd3, 5'd4, 5'd7), lw_word(5'd7, 5'd2), '0, '0, '0,
                   1'b0, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 0); // rt side
      apply_inputs(beq_word(5'd9, 5'd1), addu_word(5'd9, 5'd1, 5'd2), '0, '0, '0,
                   1'b0, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 0);
      check_value("id_ex_ctrl.clr", int'(id_ex_ctrl.clr), 1);
   endtask

   task automatic md_busy_stall();
      apply_inputs(mult_word(5'd2, 5'd3), '0, '0, '0, '0, 1'b1, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 0);
      apply_inputs(mult_word(5'd2, 5'd3), '0, '0, '0, '0, 1'b0, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 1);
      apply_inputs(addu_word(5'd3, 5'd1, 5'd2), '0, '0, '0, '0, 1'b1, 1'b1, 1'b1);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 1);
   endtask

   task automatic memory_backpressure();
      apply_inputs('0, '0, sw_word(5'd5, 5'd6), '0, '0, 1'b0, 1'b0, 1'b1);
      check_value("ex_mem_en", int'(ex_mem_en), 0);
      check_value("id_ex_ctrl.en", int'(id_ex_ctrl.en), 0);
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 0);
      check_value("data_sram_wr", int'(data_sram_wr), 1);
      check_value("mem_mmid_ctrl.en", int'(mem_mmid_ctrl.en), 1);
      check_value("mem_mmid_ctrl.clr", int'(mem_mmid_ctrl.clr), 1);
      apply_inputs('0, '0, sw_word(5'd5, 5'd6), '0, '0, 1'b0, 1'b1, 1'b1);
      check_value("ex_mem_en", int'(ex_mem_en), 1); // address accepted
      check_value("if_id_ctrl.en", int'(if_id_ctrl.en), 1);
      check_value("mem_mmid_ctrl.clr", int'(mem_mmid_ctrl.clr), 0);
      apply_inputs('0, '0, '0, lw_word(5'd8, 5'd1), '0, 1'b0, 1'b1, 1'b0);
      check_value("mem_mmid_ctrl.en", int'(mem_mmid_ctrl.en), 0);
      check_value("ex_mem_en", int'(ex_mem_en), 0);
      check_value("data_sram_wr", int'(data_sram_wr), 0);
      check_value("mmid_wb_ctrl.en", int'(mmid_wb_ctrl.en), 1);
      check_value("mmid_wb_ctrl.clr", int'(mmid_wb_ctrl.clr), 1);
      apply_inputs('0, addu_word(5'd3, 5'd10, 5'd0), '0, lw_word(5'd8, 5'd1),
                   addu_word(5'd10, 5'd1, 5'd2), 1'b0, 1'b1, 1'b0);
      check_value("fwd_rs_e", int'(fwd_rs_e), int'(fwd_e_w_alu));
      check_value("mmid_wb_ctrl.en", int'(mmid_wb_ctrl.en), 0); // W value held for E
      check_value("mmid_wb_ctrl.clr", int'(mmid_wb_ctrl.clr), 0);
   endtask

   initial begin
      seed_init = $urandom(48344);
      reset       <= 1'b1;
      instr_d     <= '0;
      instr_e     <= '0;
      instr_m     <= '0;
      instr_mmid  <= '0;
      instr_w     <= '0;
      md_busy     <= 1'b0;
      mem_addr_ok <= 1'b1;
      mem_data_ok <= 1'b1;
      repeat (3) @(posedge clk);
      reset <= 1'b0;
      e_forwarding_random();
      d_forwarding();
      load_and_branch_stall();
      md_busy_stall();
      memory_backpressure();
      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

/* project.f */
source/hazard_pkg.sv
source/instr_classifier.sv
source/stall_detector.sv
source/forward_unit.sv
source/pipeline_ctrl.sv
source/hazard_unit.sv
verif/hazard_unit_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert -f project.f --top-module hazard_unit_tb \
   -o hazard_unit_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/hazard_unit_sim > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -qx "TEST RESULT: PASS" "$log_file"; then
   exit 0
fi
exit 1
